// File: rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      byte_en_t;
  typedef logic [2:0]      funct3_t;

  // major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  // branch compares
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // load and store sizes
  localparam funct3_t f3_byte   = 3'b000;
  localparam funct3_t f3_half   = 3'b001;
  localparam funct3_t f3_word   = 3'b010;
  localparam funct3_t f3_byte_u = 3'b100;
  localparam funct3_t f3_half_u = 3'b101;

  // funct7 for sub and sra/srai
  localparam logic [6:0] funct7_alt = 7'd32;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic {a_rs1, a_pc} a_sel_e;
  typedef enum logic {b_rs2, b_imm} b_sel_e;

  typedef enum logic [1:0] {wb_alu, wb_load, wb_pc4, wb_imm} wb_sel_e;

  localparam word_t reset_pc   = '0;
  localparam word_t insn_bytes = 32'd4;

endpackage

// File: rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
  input  rv_pkg::word_t     insn,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output logic              reg_we,
  output rv_pkg::word_t     imm,
  output rv_pkg::alu_op_e   alu_op,
  output rv_pkg::a_sel_e    a_sel,
  output rv_pkg::b_sel_e    b_sel,
  output rv_pkg::wb_sel_e   wb_sel,
  output logic              is_branch,
  output logic              is_jal,
  output logic              is_jalr,
  output logic              is_load,
  output logic              is_store,
  output rv_pkg::funct3_t   funct3,
  output logic              halt,
  output logic              illegal
);

  rv_pkg::opcode_e opcode;
  logic [6:0]      funct7;
  logic            is_ecall;
  rv_pkg::word_t   imm_i, imm_s, imm_b, imm_j, imm_u;

  function automatic rv_pkg::alu_op_e alu_map(input rv_pkg::funct3_t f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  assign opcode   = rv_pkg::opcode_e'(insn[6:0]);
  assign rd       = insn[11:7];
  assign funct3   = insn[14:12];
  assign rs1      = insn[19:15];
  assign rs2      = insn[24:20];
  assign funct7   = insn[31:25];
  assign is_ecall = (opcode == rv_pkg::op_system) && (insn[31:7] == '0);

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    reg_we    = 1'b0;
    imm       = imm_i;
    alu_op    = rv_pkg::alu_add;
    a_sel     = rv_pkg::a_rs1;
    b_sel     = rv_pkg::b_imm;
    wb_sel    = rv_pkg::wb_alu;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    halt      = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      rv_pkg::op_lui: begin
        reg_we = 1'b1;
        imm    = imm_u;
        wb_sel = rv_pkg::wb_imm;
      end
      rv_pkg::op_auipc: begin
        reg_we = 1'b1;
        imm    = imm_u;
        a_sel  = rv_pkg::a_pc;
      end
      rv_pkg::op_jal: begin
        reg_we = 1'b1;
        imm    = imm_j;
        wb_sel = rv_pkg::wb_pc4;
        is_jal = 1'b1;
      end
      rv_pkg::op_jalr: begin
        reg_we  = 1'b1;
        wb_sel  = rv_pkg::wb_pc4;
        is_jalr = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      rv_pkg::op_branch: begin
        imm       = imm_b;
        b_sel     = rv_pkg::b_rs2;
        is_branch = 1'b1;
        illegal   = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      rv_pkg::op_load: begin
        reg_we  = 1'b1;
        wb_sel  = rv_pkg::wb_load;
        is_load = 1'b1;
        illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      rv_pkg::op_store: begin
        imm      = imm_s;
        is_store = 1'b1;
        illegal  = (funct3 > rv_pkg::f3_word);
      end
      rv_pkg::op_imm: begin
        reg_we = 1'b1;
        alu_op = alu_map(funct3, funct3 == 3'b101 && funct7 == rv_pkg::funct7_alt);
        // shift immediates only allow funct7 of zero, or alt for srai
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          illegal = !(funct7 == 7'd0 ||
                      (funct3 == 3'b101 && funct7 == rv_pkg::funct7_alt));
        end
      end
      rv_pkg::op_reg: begin
        reg_we  = 1'b1;
        b_sel   = rv_pkg::b_rs2;
        alu_op  = alu_map(funct3, funct7 == rv_pkg::funct7_alt);
        illegal = !(funct7 == 7'd0 || (funct7 == rv_pkg::funct7_alt &&
                    (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      rv_pkg::op_system: begin
        halt    = is_ecall;
        illegal = !is_ecall;
      end
      // fence lands here too
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      reg_we    = 1'b0;
      is_branch = 1'b0;
      is_jalr   = 1'b0;
      is_load   = 1'b0;
      is_store  = 1'b0;
    end
  end

endmodule

// File: rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  logic              we,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  localparam int num_regs = 2 ** $bits(rv_pkg::reg_addr_t);

  // x0 has no storage
  rv_pkg::word_t regs [1:num_regs-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_e op,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // only the low five bits shift in RV32
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_pkg::alu_add: begin
        result = a + b;
      end
      rv_pkg::alu_sub: begin
        result = a - b;
      end
      rv_pkg::alu_sll: begin
        result = a << shamt;
      end
      rv_pkg::alu_slt: begin
        result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
      end
      rv_pkg::alu_sltu: begin
        result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
      end
      rv_pkg::alu_xor: begin
        result = a ^ b;
      end
      rv_pkg::alu_srl: begin
        result = a >> shamt;
      end
      rv_pkg::alu_sra: begin
        // sign bit fills from the left
        result = $signed(a) >>> shamt;
      end
      rv_pkg::alu_or: begin
        result = a | b;
      end
      rv_pkg::alu_and: begin
        result = a & b;
      end
      default: begin
        result = a + b;
      end
    endcase
  end

endmodule

// File: rv_next_pc.sv
`timescale 1ns/10ps

module rv_next_pc (
  input  logic            clk,
  input  logic            rst,
  input  logic            is_branch,
  input  logic            is_jal,
  input  logic            is_jalr,
  input  rv_pkg::funct3_t funct3,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::word_t   imm,
  output rv_pkg::word_t   pc,
  output rv_pkg::word_t   pc_plus4
);

  logic          take;
  rv_pkg::word_t jalr_target;
  rv_pkg::word_t pc_next;

  always_comb begin
    case (funct3)
      rv_pkg::f3_beq:  take = (rs1_data == rs2_data);
      rv_pkg::f3_bne:  take = (rs1_data != rs2_data);
      rv_pkg::f3_blt:  take = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::f3_bge:  take = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::f3_bltu: take = (rs1_data < rs2_data);
      rv_pkg::f3_bgeu: take = (rs1_data >= rs2_data);
      default:         take = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + rv_pkg::insn_bytes;

  // jalr drops bit 0 of the sum
  assign jalr_target = (rs1_data + imm) & ~rv_pkg::word_t'(1);

  always_comb begin
    if (is_jalr) begin
      pc_next = jalr_target;
    end else if (is_jal || (is_branch && take)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pkg::reset_pc;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// File: rv_lsu.sv
`timescale 1ns/10ps

module rv_lsu (
  input  logic             is_load,
  input  logic             is_store,
  input  rv_pkg::funct3_t  funct3,
  input  rv_pkg::word_t    addr,
  input  rv_pkg::word_t    store_src,
  input  rv_pkg::word_t    dmem_rdata,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output rv_pkg::byte_en_t dmem_be,
  output rv_pkg::word_t    load_data
);

  logic [1:0]    offset;
  logic [4:0]    bit_shift;
  rv_pkg::word_t rdata_shifted;

  assign offset    = addr[1:0];
  assign bit_shift = {offset, 3'b000};

  assign dmem_addr  = {addr[rv_pkg::xlen-1:2], 2'b00};
  assign dmem_wdata = store_src << bit_shift;

  // lanes follow the byte offset inside the word
  always_comb begin
    dmem_be = '0;
    if (is_store) begin
      case (funct3)
        rv_pkg::f3_byte: dmem_be = rv_pkg::byte_en_t'(4'b0001 << offset);
        rv_pkg::f3_half: dmem_be = rv_pkg::byte_en_t'(4'b0011 << offset);
        rv_pkg::f3_word: dmem_be = 4'b1111;
        default:         dmem_be = '0;
      endcase
    end
  end

  assign rdata_shifted = dmem_rdata >> bit_shift;

  always_comb begin
    load_data = '0;
    if (is_load) begin
      case (funct3)
        rv_pkg::f3_byte:   load_data = {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
        rv_pkg::f3_half:   load_data = {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
        rv_pkg::f3_byte_u: load_data = {24'b0, rdata_shifted[7:0]};
        rv_pkg::f3_half_u: load_data = {16'b0, rdata_shifted[15:0]};
        default:           load_data = rdata_shifted;
      endcase
    end
  end

endmodule

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    insn,
  input  rv_pkg::word_t    dmem_rdata,
  output rv_pkg::word_t    pc,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output rv_pkg::byte_en_t dmem_be,
  output logic             halt
);

  rv_pkg::reg_addr_t rs1, rs2, rd;
  logic              reg_we;
  rv_pkg::word_t     imm;
  rv_pkg::alu_op_e   alu_op;
  rv_pkg::a_sel_e    a_sel;
  rv_pkg::b_sel_e    b_sel;
  rv_pkg::wb_sel_e   wb_sel;
  logic              is_branch, is_jal, is_jalr, is_load, is_store;
  rv_pkg::funct3_t   funct3;
  rv_pkg::word_t     rs1_data, rs2_data, rd_data;
  rv_pkg::word_t     alu_a, alu_b, alu_result;
  rv_pkg::word_t     pc_plus4, load_data;

  rv_decoder decoder0 (
    .insn(insn), .rs1(rs1), .rs2(rs2), .rd(rd), .reg_we(reg_we), .imm(imm),
    .alu_op(alu_op), .a_sel(a_sel), .b_sel(b_sel), .wb_sel(wb_sel),
    .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .is_load(is_load), .is_store(is_store), .funct3(funct3),
    .halt(halt), .illegal()
  );

  rv_regfile regfile0 (
    .clk(clk), .rst(rst), .we(reg_we), .rs1(rs1), .rs2(rs2), .rd(rd),
    .rd_data(rd_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_a = (a_sel == rv_pkg::a_pc) ? pc : rs1_data;
  assign alu_b = (b_sel == rv_pkg::b_imm) ? imm : rs2_data;

  rv_alu alu0 (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result));

  rv_next_pc next_pc0 (
    .clk(clk), .rst(rst), .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
    .funct3(funct3), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
    .pc(pc), .pc_plus4(pc_plus4)
  );

  // alu result doubles as the data address
  // store lanes stay closed while in reset
  rv_lsu lsu0 (
    .is_load(is_load), .is_store(is_store && !rst), .funct3(funct3), .addr(alu_result),
    .store_src(rs2_data), .dmem_rdata(dmem_rdata), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_be(dmem_be), .load_data(load_data)
  );

  always_comb begin
    case (wb_sel)
      rv_pkg::wb_alu:  rd_data = alu_result;
      rv_pkg::wb_load: rd_data = load_data;
      rv_pkg::wb_pc4:  rd_data = pc_plus4;
      default:         rd_data = imm;
    endcase
  end

endmodule

// File: tb_rv_core_assert.sv
`timescale 1ns/10ps

module tb_rv_core_assert (
  input logic             clk,
  input logic             rst,
  input rv_pkg::word_t    pc,
  input rv_pkg::byte_en_t dmem_be
);

  // no stores may leave the core while it is held in reset
  be_quiet_in_reset: assert property (@(posedge clk) rst |-> dmem_be == '0)
    else $error("dmem_be active during reset");

  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc not a multiple of 4");

  // byte, aligned half or full word only
  store_lanes_aligned: assert property (@(posedge clk) disable iff (rst)
    (dmem_be != '0) |->
    (dmem_be inside {4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111}))
    else $error("store lanes not naturally aligned");

endmodule

bind rv_core tb_rv_core_assert asserts0 (
  .clk(clk), .rst(rst), .pc(pc), .dmem_be(dmem_be)
);

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

  localparam int mem_words = 256;
  localparam int total_prog_words = 198;
  localparam int watchdog_ns = (total_prog_words * 10 + 6 * 6) * 10;
  localparam rv_pkg::word_t ecall_insn = 32'h00000073;

  logic             clk;
  logic             rst;
  rv_pkg::word_t    insn, dmem_rdata, pc, dmem_addr, dmem_wdata;
  rv_pkg::byte_en_t dmem_be;
  logic             halt;

  rv_pkg::word_t    imem [0:mem_words-1];
  rv_pkg::word_t    dmem [0:mem_words-1];
  rv_pkg::word_t    prog [$];
  rv_pkg::word_t    trace [$];
  rv_pkg::byte_en_t be_trace [$];
  rv_pkg::word_t    halt_pc;
  integer           seed = 21652;
  int               errors = 0;

  rv_core dut0 (
    .clk(clk), .rst(rst), .insn(insn), .dmem_rdata(dmem_rdata), .pc(pc),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_be(dmem_be), .halt(halt)
  );

  assign insn       = imem[pc[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (dmem_be[i]) dmem[dmem_addr[9:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("ERROR: watchdog expired, the core never reached ECALL");
    $display("Testbench failed");
    $finish;
  end

  task automatic check_eq(rv_pkg::word_t got, rv_pkg::word_t exp, string what);
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // instruction builders append to prog
  task automatic emit(rv_pkg::word_t w);
    prog.push_back(w);
  endtask

  task automatic emit_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    emit({f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'h33});
  endtask

  task automatic emit_i(logic [6:0] op, logic [2:0] f3, int rd, int rs1, int imm);
    emit({imm[11:0], rs1[4:0], f3, rd[4:0], op});
  endtask

  task automatic emit_s(logic [2:0] f3, int rs2, int off);
    emit({off[11:5], rs2[4:0], 5'd0, f3, off[4:0], 7'h23});
  endtask

  task automatic emit_b(logic [2:0] f3, int rs1, int rs2, int off);
    emit({off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63});
  endtask

  task automatic emit_u(logic [6:0] op, int rd, rv_pkg::word_t v);
    emit({v[31:12], rd[4:0], op});
  endtask

  // lui then addi with the upper part rounded for the signed low half
  task automatic load_imm(int rd, rv_pkg::word_t v);
    rv_pkg::word_t up;
    up = v + 32'h800;
    emit_u(7'h37, rd, up);
    emit_i(7'h13, 3'b000, rd, rd, int'(v));
  endtask

  function automatic rv_pkg::word_t pc_after(rv_pkg::word_t p);
    for (int i = 0; i + 1 < trace.size(); i++) begin
      if (trace[i] == p) return trace[i+1];
    end
    return 32'hffffffff;
  endfunction

  function automatic rv_pkg::word_t be_at(rv_pkg::word_t p);
    for (int i = 0; i < trace.size(); i++) begin
      if (trace[i] == p) return {28'b0, be_trace[i]};
    end
    return 32'hffffffff;
  endfunction

  // reset, load the program during reset, then step until halt
  task automatic run_prog();
    rst = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = ecall_insn;
      dmem[i] = '0;
    end
    foreach (prog[i]) imem[i] = prog[i];
    repeat (3) @(posedge clk);
    #1;
    check_eq(pc, rv_pkg::reset_pc, "pc after reset");
    check_eq({28'b0, dmem_be}, '0, "dmem_be during reset");
    rst = 1'b0;
    trace.delete();
    be_trace.delete();
    while (!halt) begin
      trace.push_back(pc);
      be_trace.push_back(dmem_be);
      @(posedge clk);
      #1;
    end
    halt_pc = pc;
  endtask

  task automatic test_arith();
    rv_pkg::word_t a, b, r, auipc_pc;
    int k;
    a = $random(seed);
    b = $random(seed);
    r = $random(seed);
    k = int'(r[11:0]) - 2048;
    prog.delete();
    // a store sits at reset_pc while rst is high
    emit_s(3'b010, 0, 28);
    load_imm(1, a);
    load_imm(2, b);
    emit_r(7'h00, 3'b000, 3, 1, 2);
    emit_s(3'b010, 3, 0);
    emit_r(7'h20, 3'b000, 3, 1, 2);
    emit_s(3'b010, 3, 4);
    emit_r(7'h00, 3'b100, 3, 1, 2);
    emit_s(3'b010, 3, 8);
    emit_r(7'h00, 3'b110, 3, 1, 2);
    emit_s(3'b010, 3, 12);
    emit_r(7'h00, 3'b111, 3, 1, 2);
    emit_s(3'b010, 3, 16);
    emit_i(7'h13, 3'b000, 5, 1, k);
    emit_s(3'b010, 5, 20);
    auipc_pc = prog.size() * 4;
    emit_u(7'h17, 6, 32'h12345000);
    emit_s(3'b010, 6, 24);
    emit(ecall_insn);
    run_prog();
    check_eq(dmem[0], a + b, "add");
    check_eq(dmem[1], a - b, "sub");
    check_eq(dmem[2], a ^ b, "xor");
    check_eq(dmem[3], a | b, "or");
    check_eq(dmem[4], a & b, "and");
    check_eq(dmem[5], a + rv_pkg::word_t'(k), "addi");
    check_eq(dmem[6], auipc_pc + 32'h12345000, "auipc");
  endtask

  task automatic test_shift_compare();
    rv_pkg::word_t a, b, c, srl_exp;
    logic [4:0] sh;
    a = $random(seed) | 32'h80000000;
    b = $random(seed);
    c = 32'd1234;
    sh = b[4:0];
    srl_exp = a >> sh;
    prog.delete();
    load_imm(1, a);
    load_imm(2, b);
    load_imm(7, c);
    load_imm(8, 32'h80000000);
    emit_r(7'h00, 3'b001, 3, 1, 2);
    emit_s(3'b010, 3, 0);
    emit_r(7'h00, 3'b101, 3, 1, 2);
    emit_s(3'b010, 3, 4);
    emit_r(7'h20, 3'b101, 3, 1, 2);
    emit_s(3'b010, 3, 8);
    emit_i(7'h13, 3'b001, 3, 1, 7);
    emit_s(3'b010, 3, 12);
    emit_i(7'h13, 3'b101, 3, 1, 7);
    emit_s(3'b010, 3, 16);
    emit_i(7'h13, 3'b101, 3, 1, 32'h407);
    emit_s(3'b010, 3, 20);
    emit_r(7'h00, 3'b010, 3, 1, 7);
    emit_s(3'b010, 3, 24);
    emit_r(7'h00, 3'b011, 3, 1, 7);
    emit_s(3'b010, 3, 28);
    emit_i(7'h13, 3'b010, 3, 1, -1);
    emit_s(3'b010, 3, 32);
    emit_i(7'h13, 3'b011, 3, 7, 1);
    emit_s(3'b010, 3, 36);
    emit_i(7'h13, 3'b101, 3, 8, 32'h41f);
    emit_s(3'b010, 3, 40);
    // x0 must stay zero after a write
    emit_s(3'b010, 1, 44);
    emit_i(7'h13, 3'b000, 0, 1, 5);
    emit_s(3'b010, 0, 44);
    emit(ecall_insn);
    run_prog();
    check_eq(dmem[0], a << sh, "sll");
    check_eq(dmem[1], srl_exp, "srl");
    check_eq(dmem[2], srl_exp | ~(32'hffffffff >> sh), "sra of negative");
    check_eq(dmem[3], a << 7, "slli");
    check_eq(dmem[4], a >> 7, "srli");
    check_eq(dmem[5], (a >> 7) | 32'hfe000000, "srai");
    check_eq(dmem[6], 32'd1, "slt negative vs positive");
    check_eq(dmem[7], 32'd0, "sltu large vs small");
    check_eq(dmem[8], {31'b0, a != 32'hffffffff}, "slti -1");
    check_eq(dmem[9], 32'd0, "sltiu 1234 vs 1");
    check_eq(dmem[10], 32'hffffffff, "srai 31 of min");
    check_eq(dmem[11], 32'd0, "store of x0");
  endtask

  task automatic test_branches();
    logic [2:0]    f3s [6];
    rv_pkg::word_t av [12];
    rv_pkg::word_t bv [12];
    rv_pkg::word_t bpc [12];
    logic          taken;
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    // even entries take the branch, odd ones fall through
    av = '{5, 5, 5, 5, 32'hfffffffd, 2, 2, 32'hfffffffd, 2, 32'hfffffffd,
           32'hfffffffd, 2};
    bv = '{5, 6, 6, 5, 2, 32'hfffffffd, 32'hfffffffd, 2, 32'hfffffffd, 2,
           2, 32'hfffffffd};
    prog.delete();
    for (int i = 0; i < 12; i++) begin
      load_imm(1, av[i]);
      load_imm(2, bv[i]);
      emit_i(7'h13, 3'b000, 3, 0, i + 1);
      bpc[i] = prog.size() * 4;
      emit_b(f3s[i/2], 1, 2, 8);
      emit_s(3'b010, 3, 4 * i);
    end
    emit(ecall_insn);
    run_prog();
    for (int i = 0; i < 12; i++) begin
      taken = (i % 2 == 0);
      check_eq(dmem[i], taken ? 32'd0 : i + 1, "branch marker");
      check_eq(pc_after(bpc[i]), bpc[i] + (taken ? 32'd8 : 32'd4), "pc after branch");
    end
  endtask

  task automatic test_jumps();
    prog.delete();
    emit({1'b0, 10'd6, 1'b0, 8'd0, 5'd1, 7'h6f});
    emit_i(7'h13, 3'b000, 9, 0, 1);
    emit_i(7'h13, 3'b000, 9, 0, 1);
    emit_s(3'b010, 1, 0);
    load_imm(5, 32'd33);
    emit_i(7'h67, 3'b000, 2, 5, 0);
    emit_i(7'h13, 3'b000, 9, 0, 2);
    emit_s(3'b010, 2, 4);
    emit_s(3'b010, 9, 8);
    emit(ecall_insn);
    run_prog();
    check_eq(dmem[0], 32'd4, "jal link");
    check_eq(dmem[1], 32'd28, "jalr link");
    check_eq(dmem[2], 32'd0, "skipped instructions");
    check_eq(pc_after(0), 32'd12, "jal target");
    check_eq(pc_after(24), 32'd32, "jalr target with bit 0 cleared");
  endtask

  task automatic test_byte_half();
    rv_pkg::word_t v, spc [6];
    logic [7:0]    bt;
    logic [15:0]   hw;
    v = 32'h80f17f82;
    prog.delete();
    for (int off = 0; off < 4; off++) begin
      emit_i(7'h13, 3'b000, 1, 0, 32'h40 + off);
      spc[off] = prog.size() * 4;
      emit_s(3'b000, 1, off);
    end
    load_imm(3, 32'h5a6b);
    spc[4] = prog.size() * 4;
    emit_s(3'b001, 3, 4);
    load_imm(3, 32'h7c8d);
    spc[5] = prog.size() * 4;
    emit_s(3'b001, 3, 6);
    load_imm(1, v);
    emit_s(3'b010, 1, 32);
    for (int n = 0; n < 12; n++) begin
      if (n < 4) emit_i(7'h03, 3'b000, 4, 0, 32 + n);
      else if (n < 8) emit_i(7'h03, 3'b100, 4, 0, 28 + n);
      else if (n < 10) emit_i(7'h03, 3'b001, 4, 0, 32 + 2 * (n - 8));
      else emit_i(7'h03, 3'b101, 4, 0, 32 + 2 * (n - 10));
      emit_s(3'b010, 4, 40 + 4 * n);
    end
    emit(ecall_insn);
    run_prog();
    for (int off = 0; off < 4; off++) begin
      check_eq(be_at(spc[off]), 32'd1 << off, "sb lanes");
    end
    check_eq(be_at(spc[4]), 32'h3, "sh lanes offset 0");
    check_eq(be_at(spc[5]), 32'hc, "sh lanes offset 2");
    check_eq(dmem[0], 32'h43424140, "sb contents");
    check_eq(dmem[1], 32'h7c8d5a6b, "sh contents");
    for (int n = 0; n < 4; n++) begin
      bt = v[8*n +: 8];
      check_eq(dmem[10+n], {{24{bt[7]}}, bt}, "lb");
      check_eq(dmem[14+n], {24'b0, bt}, "lbu");
    end
    for (int n = 0; n < 2; n++) begin
      hw = v[16*n +: 16];
      check_eq(dmem[18+n], {{16{hw[15]}}, hw}, "lh");
      check_eq(dmem[20+n], {16'b0, hw}, "lhu");
    end
  endtask

  task automatic test_ecall();
    prog.delete();
    for (int i = 0; i < 5; i++) emit_i(7'h13, 3'b000, 10, 10, 1);
    emit(ecall_insn);
    run_prog();
    check_eq(halt_pc, 32'd20, "halt pc");
    check_eq(trace.size(), 32'd5, "cycles before halt");
    for (int i = 0; i < trace.size(); i++) check_eq(trace[i], 4 * i, "pc before halt");
  endtask

  initial begin
    rst = 1'b1;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = ecall_insn;
      dmem[i] = '0;
    end
    test_arith();
    test_shift_compare();
    test_branches();
    test_jumps();
    test_byte_half();
    test_ecall();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: rv_core.f
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_next_pc.sv
rv_lsu.sv
rv_core.sv
tb_rv_core_assert.sv
tb_rv_core.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f rv_core.f

out=$(./obj_dir/Vtb_rv_core)
echo "$out"

# the pass line must appear on its own
grep -qx "Testbench passed" <<< "$out"
